//--- fpu_mul_top.f
design/fpu_format_pkg.sv
design/fpu_flags_pkg.sv
design/fpu_operand_if.sv
design/fpu_operand_classify.sv
design/fpu_mul_pipe_ctrl.sv
design/fpu_stage_reg.sv
design/fpu_mul_arith.sv
design/fpu_result_select.sv
design/fpu_mul_top.sv
verification/fpu_mul_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary -j 0
TOP       ?= fpu_mul_tb
FILELIST  ?= fpu_mul_top.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- verification/fpu_mul_tb.sv
// floating-point multiplier testbench
`timescale 1ns/1ps

module fpu_mul_tb
  import fpu_format_pkg::*;
();

  localparam int e_c = default_exp_width_c;
  localparam int m_c = default_man_width_c;
  localparam int w_c = e_c + m_c + 1;
  localparam int n_random_c = 150;
  localparam int n_fixed_c  = 15;
  localparam int n_bp_c     = 60;
  localparam int n_en_c     = 30;
  localparam int total_ops_c = n_random_c + n_fixed_c + n_bp_c + n_en_c;
  localparam int reset_cycles_c = 8;
  localparam int drain_limit_c  = 20; // idle cycles before results count as lost

  logic clk_i, reset_i, en_i, v_i, yumi_i;
  logic [w_c-1:0] a_i, b_i, z_o;
  logic ready_o, v_o, invalid_o, overflow_o, underflow_o, unimplemented_o;

  integer seed = 5;
  int errors = 0;
  int tests = 0;
  int failed_tests = 0;
  logic [w_c+3:0] exp_q[$];  // {flags, word} per accepted pair
  logic [w_c-1:0] src_a[$];
  logic [w_c-1:0] src_b[$];
  logic           held = 1'b0;
  logic           held_v;
  logic [w_c-1:0] held_z;

  fpu_mul_top dut (
    .clk_i, .reset_i, .en_i, .v_i, .a_i, .b_i, .ready_o, .v_o, .z_o,
    .invalid_o, .overflow_o, .underflow_o, .unimplemented_o, .yumi_i
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // expected {invalid, overflow, underflow, unimplemented, word}
  function automatic logic [w_c+3:0] ref_mul(logic [31:0] a, logic [31:0] b);
    logic sign, nan_a, nan_b, g, st, lsb, up;
    int ea, eb, sum, e2;
    logic [63:0] p, man;
    sign = a[31] ^ b[31];
    ea = int'(a[30:23]);
    eb = int'(b[30:23]);
    nan_a = (ea == 255) && (a[22:0] != 0);
    nan_b = (eb == 255) && (b[22:0] != 0);
    if ((nan_a && !a[22]) || (nan_b && !b[22])) return {4'b1000, 32'(make_sig_nan(8, 23))};
    if (nan_a || nan_b) return {4'b0000, 32'(make_quiet_nan(8, 23))};
    if (ea == 255 || eb == 255) begin
      if (a[30:0] == 0 || b[30:0] == 0) return {4'b1000, 32'(make_quiet_nan(8, 23))};
      return {4'b0000, 32'(make_infty(sign, 8, 23))};
    end
    if (a[30:0] == 0 || b[30:0] == 0) return {4'b0000, 32'(make_zero(sign, 8, 23))};
    if (ea == 0 && eb == 0) return {4'b0010, 32'(make_zero(sign, 8, 23))};
    if (ea == 0 || eb == 0) return {4'b0001, 32'(make_quiet_nan(8, 23))};
    sum = ea + eb + 1;
    if (sum < 128) return {4'b0010, 32'(make_zero(sign, 8, 23))};
    if (sum >= 384) return {4'b0100, 32'(make_infty(sign, 8, 23))};
    p = {40'd1, a[22:0]} * {40'd1, b[22:0]};
    if (p[47]) begin  // product in [2,4)
      e2 = sum - 127;
      man = (p >> 24) & 64'h7f_ffff;
      lsb = p[24];
      g = p[23];
      st = |p[22:0];
    end else begin
      e2 = sum - 128;
      man = (p >> 23) & 64'h7f_ffff;
      lsb = p[23];
      g = p[22];
      st = |p[21:0];
    end
    up = g & (st | lsb);
    if (e2 >= 255) return {4'b0100, 32'(make_infty(sign, 8, 23))};
    man = man + 64'(up);
    if (man[23]) begin  // carry into the exponent
      if (e2 + 1 >= 255) return {4'b0100, 32'(make_infty(sign, 8, 23))};
      return {4'b0000, sign, 8'(e2 + 1), 23'd0};
    end
    if (e2 == 0) return {4'b0010, 32'(make_zero(sign, 8, 23))};
    return {4'b0000, sign, 8'(e2), man[22:0]};
  endfunction

  function automatic logic [31:0] rand_normal();
    logic [31:0] r;
    r = $random(seed);
    r[30:23] = 8'd64 + 8'($random(seed) & 127);  // away from the extremes
    return r;
  endfunction

  // input capture and result compare
  always @(posedge clk_i) begin
    logic [w_c+3:0] exp_v;
    if (!reset_i) begin
      if (v_i && ready_o) exp_q.push_back(ref_mul(a_i, b_i));
      if (held && (v_o !== held_v || (held_v && z_o !== held_z))) begin
        $display("FAIL %0t: output moved while held", $time);
        errors++;
      end
      if (v_o && !yumi_i && ready_o) begin
        $display("FAIL %0t: ready_o high during stall", $time);
        errors++;
      end
      if (!en_i && ready_o) begin
        $display("FAIL %0t: ready_o high with en_i low", $time);
        errors++;
      end
      if (v_o && yumi_i) begin
        if (exp_q.size() == 0) begin
          $display("a result came out with no operands waiting for it");
          errors++;
        end else begin
          exp_v = exp_q.pop_front();
          if (z_o !== exp_v[w_c-1:0]) begin
            $display("FAIL %0t: z_o %h expected %h", $time, z_o, exp_v[w_c-1:0]);
            errors++;
          end
          if ({invalid_o, overflow_o, underflow_o, unimplemented_o} !== exp_v[w_c+3:w_c]) begin
            $display("FAIL %0t: flags %b expected %b", $time,
                     {invalid_o, overflow_o, underflow_o, unimplemented_o}, exp_v[w_c+3:w_c]);
            errors++;
          end
        end
      end
      held = (v_o && !yumi_i) || !en_i;
      held_v = v_o;
      held_z = z_o;
    end
  end

  task automatic add_pair(logic [31:0] a, logic [31:0] b);
    src_a.push_back(a);
    src_b.push_back(b);
  endtask

  // feeds src_a/src_b and drains the pipeline
  task automatic run_stream(string name, int yumi_pct, int gap_start, int gap_len);
    int idx, cyc, err0, r, idle;
    logic accepted;
    idx = 0;
    cyc = 0;
    idle = 0;
    err0 = errors;
    forever begin
      @(negedge clk_i);
      if (idx == src_a.size() && !v_o) begin
        if (exp_q.size() == 0 || idle >= drain_limit_c) break;
        idle++;
      end else begin
        idle = 0;
      end
      en_i = !(cyc >= gap_start && cyc < gap_start + gap_len);
      v_i = idx < src_a.size();
      a_i = v_i ? src_a[idx] : '0;
      b_i = v_i ? src_b[idx] : '0;
      r = $random(seed);
      yumi_i = v_o && en_i && (((r % 100) + 100) % 100 < yumi_pct);
      #1;
      accepted = v_i && ready_o;
      @(posedge clk_i);
      if (accepted) idx++;
      cyc++;
    end
    v_i = 1'b0;
    yumi_i = 1'b0;
    en_i = 1'b1;
    if (exp_q.size() != 0) begin
      $display("results missing for %0d accepted operand pairs", exp_q.size());
      errors++;
      exp_q.delete();
    end
    tests++;
    if (errors != err0) failed_tests++;
    $display("test %s: %s, %0d products", name, (errors == err0) ? "ok" : "errors", idx);
    src_a.delete();
    src_b.delete();
  endtask

  initial begin : watchdog
    repeat (total_ops_c * 20 + 2 * reset_cycles_c) @(posedge clk_i);
    $display("timeout: the run did not finish in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    reset_i = 1'b1;
    en_i = 1'b1;
    v_i = 1'b0;
    yumi_i = 1'b0;
    a_i = '0;
    b_i = '0;
    repeat (reset_cycles_c) @(negedge clk_i);
    reset_i = 1'b0;
    #1;
    if (v_o !== 1'b0 || ready_o !== 1'b1) begin
      $display("FAIL %0t: bad state after reset", $time);
      errors++;
    end

    for (int i = 0; i < n_random_c; i++) begin
      if (i % 3 == 0) add_pair(rand_normal(), 32'h3fc0_0000);  // x1.5 gives ties
      else add_pair(rand_normal(), rand_normal());
    end
    run_stream("random normals", 100, -1, 0);

    add_pair(32'h7f80_0001, 32'h3f80_0000);  // signaling nan
    add_pair(32'h7fc0_0000, 32'h4000_0000);
    add_pair(32'h7f80_0000, 32'h0000_0000);  // inf * 0
    add_pair(32'h7f80_0000, 32'hc000_0000);
    add_pair(32'h0000_0000, 32'hc040_0000);
    add_pair(32'h8000_0000, 32'h40a0_0000);
    run_stream("special operands", 100, -1, 0);

    add_pair(32'h0000_0001, 32'h0040_0000);
    add_pair(32'h0000_0010, 32'h3f80_0000);
    add_pair(32'h3f80_0000, 32'h8000_0100);
    run_stream("denormals", 100, -1, 0);

    add_pair(32'h7f00_0000, 32'h7f00_0000);
    add_pair(32'h0080_0000, 32'h0080_0000);
    add_pair(32'h7f7f_fffe, 32'h3f80_0001);  // rounding carry to all ones
    add_pair(32'h0080_0000, 32'h3f00_0000);
    add_pair(32'hff00_0000, 32'h4000_0000);
    add_pair(32'h3f80_0000, 32'h7f7f_ffff);
    run_stream("exponent extremes", 100, -1, 0);

    for (int i = 0; i < n_bp_c; i++) add_pair(rand_normal(), rand_normal());
    run_stream("back-pressure", 40, -1, 0);

    for (int i = 0; i < n_en_c; i++) add_pair(rand_normal(), rand_normal());
    run_stream("enable gap", 100, 10, 7);

    // fill the pipeline so reset has valid items to clear
    @(negedge clk_i);
    v_i = 1'b1;
    a_i = 32'h3f80_0000;
    b_i = 32'h4000_0000;
    repeat (3) @(negedge clk_i);
    v_i = 1'b0;
    reset_i = 1'b1;
    exp_q.delete();  // in-flight items are dropped by reset
    repeat (reset_cycles_c) @(negedge clk_i);
    reset_i = 1'b0;
    #1;
    if (v_o !== 1'b0 || ready_o !== 1'b1) begin
      $display("FAIL %0t: bad state after second reset", $time);
      errors++;
    end

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- design/fpu_mul_top.sv
// pipelined floating-point multiplier
`timescale 1ns/1ps

module fpu_mul_top
  import fpu_flags_pkg::*, fpu_format_pkg::*;
#(
  parameter int e_p = default_exp_width_c,
  parameter int m_p = default_man_width_c
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             en_i,
  input  logic             v_i,
  input  logic [e_p+m_p:0] a_i,
  input  logic [e_p+m_p:0] b_i,
  output logic             ready_o,
  output logic             v_o,
  output logic [e_p+m_p:0] z_o,
  output logic             invalid_o,
  output logic             overflow_o,
  output logic             underflow_o,
  output logic             unimplemented_o,
  input  logic             yumi_i // only with v_o and en_i high
);

  typedef struct packed {
    logic           sign;
    fpu_class_t     cls_a;
    fpu_class_t     cls_b;
    logic [e_p:0]   exp_sum;
    logic [e_p-1:0] exp_unbiased;
    logic [m_p:0]   man_a;
    logic [m_p:0]   man_b;
  } stage1_t;

  typedef struct packed {
    logic             sign;
    fpu_class_t       cls_a;
    fpu_class_t       cls_b;
    logic [e_p:0]     exp_sum;
    logic [e_p-1:0]   exp_unbiased;
    logic [2*m_p+1:0] product;
  } stage2_t;

  typedef struct packed {
    logic               sign;
    fpu_class_t         cls_a;
    fpu_class_t         cls_b;
    logic [e_p:0]       exp_sum;
    logic [e_p:0]       final_exp;
    logic [e_p+m_p-1:0] pre_round;
    logic               round_up;
  } stage3_t;

  logic               advance;
  logic               valid_1;
  logic               valid_2;
  logic [e_p:0]       exp_sum;
  logic [e_p-1:0]     exp_unbiased;
  logic [m_p:0]       man_a_norm;
  logic [m_p:0]       man_b_norm;
  logic [2*m_p+1:0]   product;
  logic [e_p:0]       final_exp;
  logic [e_p+m_p-1:0] pre_round;
  logic               round_up;
  stage1_t            s1_d;
  stage1_t            s1_q;
  stage2_t            s2_d;
  stage2_t            s2_q;
  stage3_t            s3_d;
  stage3_t            s3_q;
  fpu_except_t        except;

  fpu_operand_if #(.e_p(e_p), .m_p(m_p)) op_a ();
  fpu_operand_if #(.e_p(e_p), .m_p(m_p)) op_b ();

  fpu_operand_classify #(.e_p(e_p), .m_p(m_p)) u_classify_a (
    .operand_i (a_i),
    .op_o      (op_a)
  );

  fpu_operand_classify #(.e_p(e_p), .m_p(m_p)) u_classify_b (
    .operand_i (b_i),
    .op_o      (op_b)
  );

  fpu_mul_pipe_ctrl u_ctrl (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .en_i      (en_i),
    .v_i       (v_i),
    .yumi_i    (yumi_i),
    .advance_o (advance),
    .valid_1_o (valid_1),
    .valid_2_o (valid_2),
    .valid_3_o (v_o)
  );

  fpu_mul_arith #(.e_p(e_p), .m_p(m_p)) u_arith (
    .op_a_i           (op_a),
    .op_b_i           (op_b),
    .exp_sum_o        (exp_sum),
    .exp_unbiased_o   (exp_unbiased),
    .man_a_norm_o     (man_a_norm),
    .man_b_norm_o     (man_b_norm),
    .man_a_r_i        (s1_q.man_a),
    .man_b_r_i        (s1_q.man_b),
    .product_o        (product),
    .product_r_i      (s2_q.product),
    .exp_unbiased_r_i (s2_q.exp_unbiased),
    .final_exp_o      (final_exp),
    .pre_round_o      (pre_round),
    .round_up_o       (round_up)
  );

  assign s1_d = '{sign: op_a.sign ^ op_b.sign, cls_a: op_a.cls, cls_b: op_b.cls,
                  exp_sum: exp_sum, exp_unbiased: exp_unbiased,
                  man_a: man_a_norm, man_b: man_b_norm};
  assign s2_d = '{sign: s1_q.sign, cls_a: s1_q.cls_a, cls_b: s1_q.cls_b,
                  exp_sum: s1_q.exp_sum, exp_unbiased: s1_q.exp_unbiased,
                  product: product};
  assign s3_d = '{sign: s2_q.sign, cls_a: s2_q.cls_a, cls_b: s2_q.cls_b,
                  exp_sum: s2_q.exp_sum, final_exp: final_exp,
                  pre_round: pre_round, round_up: round_up};

  fpu_stage_reg #(.payload_t(stage1_t)) u_stage_1 (
    .clk_i  (clk_i),
    .load_i (advance & v_i),
    .d_i    (s1_d),
    .q_o    (s1_q)
  );

  fpu_stage_reg #(.payload_t(stage2_t)) u_stage_2 (
    .clk_i  (clk_i),
    .load_i (advance & valid_1),
    .d_i    (s2_d),
    .q_o    (s2_q)
  );

  fpu_stage_reg #(.payload_t(stage3_t)) u_stage_3 (
    .clk_i  (clk_i),
    .load_i (advance & valid_2),
    .d_i    (s3_d),
    .q_o    (s3_q)
  );

  fpu_result_select #(.e_p(e_p), .m_p(m_p)) u_result (
    .sign_i      (s3_q.sign),
    .cls_a_i     (s3_q.cls_a),
    .cls_b_i     (s3_q.cls_b),
    .exp_sum_i   (s3_q.exp_sum),
    .final_exp_i (s3_q.final_exp),
    .pre_round_i (s3_q.pre_round),
    .round_up_i  (s3_q.round_up),
    .result_o    (z_o),
    .except_o    (except)
  );

  assign ready_o         = advance;
  assign invalid_o       = except.invalid;
  assign overflow_o      = except.overflow;
  assign underflow_o     = except.underflow;
  assign unimplemented_o = except.unimplemented;

endmodule

//--- design/fpu_result_select.sv
// rounding and exception priority
`timescale 1ns/1ps

module fpu_result_select
  import fpu_flags_pkg::*, fpu_format_pkg::*;
#(
  parameter int e_p = default_exp_width_c,
  parameter int m_p = default_man_width_c
) (
  input  logic               sign_i,
  input  fpu_class_t         cls_a_i,
  input  fpu_class_t         cls_b_i,
  input  logic [e_p:0]       exp_sum_i,
  input  logic [e_p:0]       final_exp_i,
  input  logic [e_p+m_p-1:0] pre_round_i,
  input  logic               round_up_i,
  output logic [e_p+m_p:0]   result_o,
  output fpu_except_t        except_o
);

  logic [e_p+m_p:0]   qnan;
  logic [e_p+m_p:0]   snan;
  logic [e_p+m_p:0]   infty;
  logic [e_p+m_p:0]   zero;
  logic [e_p+m_p-1:0] rounded;
  logic               carry_into_exp;
  logic               exp_sum_ufl;
  logic               exp_sum_ofl;
  logic               round_ofl;
  logic               round_ufl;

  assign qnan  = (e_p+m_p+1)'(make_quiet_nan(e_p, m_p));
  assign snan  = (e_p+m_p+1)'(make_sig_nan(e_p, m_p));
  assign infty = (e_p+m_p+1)'(make_infty(sign_i, e_p, m_p));
  assign zero  = (e_p+m_p+1)'(make_zero(sign_i, e_p, m_p));

  // increment ripples into the exponent when the mantissa is all ones
  assign carry_into_exp = round_up_i & (&pre_round_i[m_p-1:0]);
  assign rounded        = pre_round_i + (e_p+m_p)'(round_up_i);

  // top two bits of the biased sum tell range before normalization
  assign exp_sum_ufl = (exp_sum_i[e_p-:2] == 2'b00);
  assign exp_sum_ofl = (exp_sum_i[e_p-:2] == 2'b11) | final_exp_i[e_p];

  assign round_ofl = (&pre_round_i[m_p+:e_p]) | (&rounded[m_p+:e_p]);
  assign round_ufl = ~|pre_round_i[m_p+:e_p] & ~carry_into_exp; // no denormal results

  always_comb begin
    except_o = '0;
    result_o = {sign_i, rounded};
    if (cls_a_i.sig_nan | cls_b_i.sig_nan) begin
      except_o.invalid = 1'b1;
      result_o         = snan;
    end else if (cls_a_i.nan | cls_b_i.nan) begin
      result_o = qnan;
    end else if (cls_a_i.infty | cls_b_i.infty) begin
      if (cls_a_i.zero | cls_b_i.zero) begin
        except_o.invalid = 1'b1; // inf * 0
        result_o         = qnan;
      end else begin
        result_o = infty;
      end
    end else if (cls_a_i.zero | cls_b_i.zero) begin
      result_o = zero;
    end else if (cls_a_i.denormal & cls_b_i.denormal) begin
      except_o.underflow = 1'b1;
      result_o           = zero;
    end else if (cls_a_i.denormal | cls_b_i.denormal) begin
      except_o.unimplemented = 1'b1;
      result_o               = qnan;
    end else if (exp_sum_ufl) begin
      except_o.underflow = 1'b1;
      result_o           = zero;
    end else if (exp_sum_ofl | round_ofl) begin
      except_o.overflow = 1'b1;
      result_o          = infty;
    end else if (round_ufl) begin
      except_o.underflow = 1'b1;
      result_o           = zero;
    end
  end

endmodule

//--- design/fpu_mul_arith.sv
// exponent, mantissa product and round decision
`timescale 1ns/1ps

module fpu_mul_arith
  import fpu_format_pkg::*;
#(
  parameter int e_p = default_exp_width_c,
  parameter int m_p = default_man_width_c
) (
  fpu_operand_if.sink            op_a_i,
  fpu_operand_if.sink            op_b_i,
  output logic [e_p:0]           exp_sum_o,
  output logic [e_p-1:0]         exp_unbiased_o,
  output logic [m_p:0]           man_a_norm_o,
  output logic [m_p:0]           man_b_norm_o,
  input  logic [m_p:0]           man_a_r_i,
  input  logic [m_p:0]           man_b_r_i,
  output logic [2*m_p+1:0]       product_o,
  input  logic [2*m_p+1:0]       product_r_i,
  input  logic [e_p-1:0]         exp_unbiased_r_i,
  output logic [e_p:0]           final_exp_o,
  output logic [e_p+m_p-1:0]     pre_round_o,
  output logic                   round_up_o
);

  logic [e_p:0]   exp_sum;
  logic           prod_hi;
  logic           lsb;
  logic           guard;
  logic           sticky;
  logic [m_p-1:0] man_shifted;

  // stage 0: ea + eb + 1, then flipping bit e_p-1 takes off the bias
  assign exp_sum        = {1'b0, op_a_i.exp} + {1'b0, op_b_i.exp} + (e_p+1)'(1);
  assign exp_sum_o      = exp_sum;
  assign exp_unbiased_o = {~exp_sum[e_p-1], exp_sum[e_p-2:0]};

  assign man_a_norm_o = {1'b1, op_a_i.man}; // hidden bits
  assign man_b_norm_o = {1'b1, op_b_i.man};

  // stage 1
  assign product_o = man_a_r_i * man_b_r_i;

  // stage 2: product in [2,4) needs a one bit shift
  assign prod_hi = product_r_i[2*m_p+1];

  always_comb begin
    if (prod_hi) begin
      man_shifted = product_r_i[m_p+1+:m_p];
      lsb         = product_r_i[m_p+1];
      guard       = product_r_i[m_p];
      sticky      = |product_r_i[m_p-1:0];
    end else begin
      man_shifted = product_r_i[m_p+:m_p];
      lsb         = product_r_i[m_p];
      guard       = product_r_i[m_p-1];
      sticky      = |product_r_i[m_p-2:0];
    end
  end

  // nearest even: round up above half, or at half when lsb is odd
  assign round_up_o = guard & (sticky | lsb);

  assign final_exp_o = {1'b0, exp_unbiased_r_i} + (e_p+1)'(prod_hi);
  assign pre_round_o = {final_exp_o[e_p-1:0], man_shifted};

endmodule

//--- design/fpu_stage_reg.sv
// pipeline stage payload register
`timescale 1ns/1ps

module fpu_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     load_i,
  input  payload_t d_i,
  output payload_t q_o
);

  payload_t data_r;

  // hold unless the stage is loaded with a valid item
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      data_r <= d_i;
    end
  end

  assign q_o = data_r;

endmodule

//--- design/fpu_mul_pipe_ctrl.sv
// multiplier pipeline control
`timescale 1ns/1ps

module fpu_mul_pipe_ctrl (
  input  logic clk_i,
  input  logic reset_i,
  input  logic en_i,
  input  logic v_i,
  input  logic yumi_i,
  output logic advance_o,
  output logic valid_1_o,
  output logic valid_2_o,
  output logic valid_3_o
);

  logic v_1_r;
  logic v_2_r;
  logic v_3_r;
  logic stall;

  // last stage full and not taken
  assign stall     = v_3_r & ~yumi_i;
  assign advance_o = en_i & ~stall;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_1_r <= 1'b0;
      v_2_r <= 1'b0;
      v_3_r <= 1'b0;
    end else if (advance_o) begin
      v_1_r <= v_i;
      v_2_r <= v_1_r;
      v_3_r <= v_2_r;
    end
  end

  assign valid_1_o = v_1_r;
  assign valid_2_o = v_2_r;
  assign valid_3_o = v_3_r;

endmodule

//--- design/fpu_operand_classify.sv
// operand field split and classification
`timescale 1ns/1ps

module fpu_operand_classify
  import fpu_flags_pkg::*, fpu_format_pkg::*;
#(
  parameter int e_p = default_exp_width_c,
  parameter int m_p = default_man_width_c
) (
  input  logic [e_p+m_p:0] operand_i,
  fpu_operand_if.source    op_o
);

  logic [e_p-1:0] exp;
  logic [m_p-1:0] man;
  logic           exp_all_ones;
  logic           exp_zero;
  logic           man_zero;

  assign exp = operand_i[m_p+:e_p];
  assign man = operand_i[m_p-1:0];

  assign exp_all_ones = &exp;
  assign exp_zero     = ~|exp;
  assign man_zero     = ~|man;

  assign op_o.sign = operand_i[e_p+m_p];
  assign op_o.exp  = exp;
  assign op_o.man  = man;

  always_comb begin
    op_o.cls.zero     = exp_zero & man_zero;
    op_o.cls.denormal = exp_zero & ~man_zero;
    op_o.cls.infty    = exp_all_ones & man_zero;
    op_o.cls.nan      = exp_all_ones & ~man_zero;
    // quiet bit clear marks a signaling nan
    op_o.cls.sig_nan  = exp_all_ones & ~man_zero & ~man[m_p-1];
  end

endmodule

//--- design/fpu_operand_if.sv
// classified operand bundle
`timescale 1ns/1ps

interface fpu_operand_if
  import fpu_flags_pkg::*, fpu_format_pkg::*;
#(
  parameter int e_p = default_exp_width_c,
  parameter int m_p = default_man_width_c
) ();

  logic           sign;
  logic [e_p-1:0] exp;  // biased exponent field
  logic [m_p-1:0] man;  // fraction without hidden bit
  fpu_class_t     cls;

  // driven by the classifier
  modport source (
    output sign,
    output exp,
    output man,
    output cls
  );

  // read by arithmetic and payload packing
  modport sink (
    input sign,
    input exp,
    input man,
    input cls
  );

endinterface

//--- design/fpu_flags_pkg.sv
// operand class and exception flags
package fpu_flags_pkg;

  // decoded operand class, one hot except for nan/sig_nan overlap
  typedef struct packed {
    logic zero;
    logic nan;      // any nan, quiet or signaling
    logic sig_nan;  // nan with top mantissa bit clear
    logic infty;
    logic denormal; // exponent zero, mantissa nonzero
  } fpu_class_t;

  // exception flags reported with each result
  typedef struct packed {
    logic invalid;
    logic overflow;
    logic underflow;
    logic unimplemented; // denormal times normal
  } fpu_except_t;

endpackage

//--- design/fpu_format_pkg.sv
// float format defaults and canonical values
package fpu_format_pkg;

  // single precision unless the top level says otherwise
  localparam int default_exp_width_c = 8;
  localparam int default_man_width_c = 23;

  localparam int word_max_c = 64; // widest format the helpers can build
  typedef logic [word_max_c-1:0] fpu_word_t;

  // exponent field all ones, placed above the mantissa
  function automatic fpu_word_t exp_ones(int unsigned e, int unsigned m);
    return ((fpu_word_t'(1) << e) - fpu_word_t'(1)) << m;
  endfunction

  function automatic fpu_word_t make_quiet_nan(int unsigned e, int unsigned m);
    return exp_ones(e, m) | (fpu_word_t'(1) << (m - 1)); // top mantissa bit set
  endfunction

  function automatic fpu_word_t make_sig_nan(int unsigned e, int unsigned m);
    return exp_ones(e, m) | ((fpu_word_t'(1) << (m - 1)) - fpu_word_t'(1));
  endfunction

  function automatic fpu_word_t make_infty(logic sign, int unsigned e, int unsigned m);
    return exp_ones(e, m) | (fpu_word_t'(sign) << (e + m));
  endfunction

  function automatic fpu_word_t make_zero(logic sign, int unsigned e, int unsigned m);
    return fpu_word_t'(sign) << (e + m);
  endfunction

endpackage
